// ==== Makefile ====
.PHONY: sim clean

# Build and run with Verilator; the verdict comes from sim.log.
sim:
	verilator --binary --timing --assert --top-module pktout_mux_tb \
		-f pktout_mux.f --Mdir obj_dir -o pktout_mux_tb
	./obj_dir/pktout_mux_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== pktout_mux.f ====
+incdir+verilog
verilog/pktout_pkg.sv
verilog/rdq_formatter.sv
verilog/pio_formatter.sv
verilog/jbus_cycle_select.sv
verilog/jbus_parity_inject.sv
verilog/pktout_mux.sv
sim/tb_clock_gen.sv
sim/pktout_mux_asserts.sv
sim/pktout_mux_tb.sv

// ==== sim/pktout_mux_asserts.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module pktout_mux_asserts (
  input  logic                  clk,
  input  logic                  reset,
  input  pktout_pkg::lrq_e      sel_queue,
  input  pktout_pkg::jsel_e     sel_j_adbus,
  input  logic [`PKT_ADP_W-1:0] inj_err_j_ad,
  input  pktout_pkg::ad_t       j_ad
);
  import pktout_pkg::*;

  logic sct_pair;
  logic pio_pair;
  logic legal_pair;
  logic dup_cycle;

  assign sct_pair = (sel_queue inside {LRQ_SCT0RDQ, LRQ_SCT1RDQ, LRQ_SCT2RDQ, LRQ_SCT3RDQ}) &&
                    (sel_j_adbus inside {SEL_RD16, SEL_RD64_0, SEL_RD64_1, SEL_RD64_2,
                                         SEL_RD64_3, SEL_RDER});
  assign pio_pair = (sel_queue == LRQ_PIORQQ) &&
                    (sel_j_adbus inside {SEL_NCRD, SEL_NCWR_0, SEL_NCWR_1});
  assign legal_pair = sct_pair || pio_pair || (sel_j_adbus == SEL_IDLE);

  // Cycles whose two AD halves carry the same word.
  assign dup_cycle = (sel_j_adbus inside {SEL_IDLE, SEL_NCRD, SEL_NCWR_0}) &&
                     (inj_err_j_ad == '0);

  a_legal_select: assert property (@(posedge clk) disable iff (reset) legal_pair)
    else $error("queue select and bus-cycle select form an illegal pair");

  a_address_halves: assert property (@(posedge clk) disable iff (reset)
    dup_cycle |-> (j_ad[`PKT_AD_W-1:`PKT_AD_W/2] == j_ad[`PKT_AD_W/2-1:0]))
    else $error("upper and lower AD halves differ on an address or idle cycle");

endmodule

bind pktout_mux pktout_mux_asserts u_pktout_mux_asserts (
  .clk          (clk),
  .reset        (reset),
  .sel_queue    (sel_queue),
  .sel_j_adbus  (sel_j_adbus),
  .inj_err_j_ad (inj_err_j_ad),
  .j_ad         (j_ad)
);

// ==== sim/pktout_mux_tb.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module pktout_mux_tb;
  import pktout_pkg::*;

  localparam int N_TESTS        = 2000;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = N_TESTS + RESET_CYCLES + 50;

  logic                       clk;
  logic                       reset;
  lrq_e                       sel_queue;
  jsel_e                      sel_j_adbus;
  logic [`PKT_NUM_SCT-1:0]    sct_install_state;
  logic [`PKT_NUM_SCT-1:0]    sct_unmapped_error;
  logic [`PKT_NUM_SCT-1:0]    sct_ue_err;
  jid_t                       sct_jid [`PKT_NUM_SCT];
  ad_t                        sct_data [`PKT_NUM_SCT];
  logic                       pio_ue;
  logic [`PKT_BE_W-1:0]       pio_be;
  logic [`PKT_PIO_DATA_W-1:0] pio_ad;
  jid_t                       unused_jid;
  logic [`PKT_ADP_W-1:0]      inj_err_j_ad;
  adtype_t                    j_adtype;
  ad_t                        j_ad;
  adp_t                       j_adp;

  integer seed = 96939;
  int     err_adtype = 0;
  int     err_ad = 0;
  int     err_adp = 0;
  int     cycle_count = 0;

  // Model state, ue_err of the previous cycle per queue.
  logic [`PKT_NUM_SCT-1:0] prev_ue = '0;

  lrq_e  queue_list [6] = '{LRQ_SCT0RDQ, LRQ_SCT1RDQ, LRQ_SCT2RDQ, LRQ_SCT3RDQ,
                            LRQ_PIORQQ, LRQ_IDLE};
  jsel_e sct_sel_list [6] = '{SEL_RD16, SEL_RD64_0, SEL_RD64_1, SEL_RD64_2,
                              SEL_RD64_3, SEL_RDER};
  jsel_e pio_sel_list [3] = '{SEL_NCRD, SEL_NCWR_0, SEL_NCWR_1};

  tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  pktout_mux dut (
    .clk                 (clk),
    .reset               (reset),
    .sel_queue           (sel_queue),
    .sel_j_adbus         (sel_j_adbus),
    .sct0_install_state  (sct_install_state[0]),
    .sct0_unmapped_error (sct_unmapped_error[0]),
    .sct0_jid            (sct_jid[0]),
    .sct0_data           (sct_data[0]),
    .sct0_ue_err         (sct_ue_err[0]),
    .sct1_install_state  (sct_install_state[1]),
    .sct1_unmapped_error (sct_unmapped_error[1]),
    .sct1_jid            (sct_jid[1]),
    .sct1_data           (sct_data[1]),
    .sct1_ue_err         (sct_ue_err[1]),
    .sct2_install_state  (sct_install_state[2]),
    .sct2_unmapped_error (sct_unmapped_error[2]),
    .sct2_jid            (sct_jid[2]),
    .sct2_data           (sct_data[2]),
    .sct2_ue_err         (sct_ue_err[2]),
    .sct3_install_state  (sct_install_state[3]),
    .sct3_unmapped_error (sct_unmapped_error[3]),
    .sct3_jid            (sct_jid[3]),
    .sct3_data           (sct_data[3]),
    .sct3_ue_err         (sct_ue_err[3]),
    .pio_ue              (pio_ue),
    .pio_be              (pio_be),
    .pio_ad              (pio_ad),
    .unused_jid          (unused_jid),
    .inj_err_j_ad        (inj_err_j_ad),
    .j_adtype            (j_adtype),
    .j_ad                (j_ad),
    .j_adp               (j_adp)
  );

  always @(posedge clk) begin
    if (reset) begin
      prev_ue <= '0;
    end else begin
      prev_ue <= sct_ue_err;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Expected cycle before injection, straight from the format rules.
  task automatic model_cycle(output adtype_t t, output ad_t d);
    int                         q;
    jid_t                       id;
    logic [`PKT_PIO_DATA_W-1:0] half;
    t = '0;
    d = '0;
    q = int'(sel_queue);
    id = sct_jid[q[1:0]];
    if (sel_j_adbus == SEL_IDLE) begin
      t = '1;
      d = '1;
    end else if (q < `PKT_NUM_SCT && (sel_j_adbus inside {SEL_RD16, SEL_RD64_0, SEL_RD64_1,
                                                          SEL_RD64_2, SEL_RD64_3, SEL_RDER})) begin
      d = sct_data[q[1:0]];
      case (sel_j_adbus)
        SEL_RD16:   t = {2'b10, id[5:2], id[1:0]};
        SEL_RD64_0: t = {2'b01, id[5:2], id[1:0]};
        SEL_RD64_1: begin
          t[6] = prev_ue[q[1:0]];
          t[4] = sct_ue_err[q[1:0]];
          t[2:0] = sct_install_state[q[1:0]] ? INSTALL_INVALID : INSTALL_SHARED;
        end
        SEL_RDER: begin
          t = {2'b00, id[5:2], id[1:0]};
          d[2:0] = sct_unmapped_error[q[1:0]] ? RDER_UNMAPPED : RDER_BUS_ERROR;
        end
        default: t[4] = sct_ue_err[q[1:0]];
      endcase
    end else if (sel_queue == LRQ_PIORQQ) begin
      case (sel_j_adbus)
        SEL_NCRD: begin
          t = {2'b11, unused_jid};
          half = {pio_be, TRANS_NCRD, pio_ad[`PKT_PIO_ADDR_W-1:0]};
          d = {half, half};
        end
        SEL_NCWR_0: begin
          t = 8'hc0;
          half = {pio_be, TRANS_NCWR, pio_ad[`PKT_PIO_ADDR_W-1:0]};
          d = {half, half};
        end
        SEL_NCWR_1: begin
          t[4] = pio_ue;
          d = {pio_ad, pio_ad};
        end
        default: d = '0;
      endcase
    end
  endtask

  // Lane plus its parity bit hold an odd number of ones.
  function automatic adp_t lane_parity(ad_t d, adtype_t t);
    adp_t p;
    int   ones;
    for (int i = 0; i < `PKT_ADP_W; i++) begin
      ones = $countones(d[i*`PKT_LANE_W +: `PKT_LANE_W]);
      if (i == `PKT_ADP_W - 1) begin
        ones = ones + $countones(t);
      end
      p[i] = (ones % 2 == 0);
    end
    return p;
  endfunction

  function automatic ad_t apply_injection(ad_t d, logic [`PKT_ADP_W-1:0] inj);
    ad_t r;
    r = d;
    for (int i = 0; i < `PKT_ADP_W; i++) begin
      if (inj[i]) begin
        r[i*`PKT_LANE_W] = ~r[i*`PKT_LANE_W];
      end
    end
    return r;
  endfunction

  task automatic check_adtype(string name, adtype_t exp_v, adtype_t act_v);
    if (act_v !== exp_v) begin
      err_adtype++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_ad(string name, ad_t exp_v, ad_t act_v);
    if (act_v !== exp_v) begin
      err_ad++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_adp(string name, adp_t exp_v, adp_t act_v);
    if (act_v !== exp_v) begin
      err_adp++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_outputs();
    adtype_t exp_adtype;
    ad_t     exp_raw;
    model_cycle(exp_adtype, exp_raw);
    check_adtype("j_adtype", exp_adtype, j_adtype);
    check_ad("j_ad", apply_injection(exp_raw, inj_err_j_ad), j_ad);
    check_adp("j_adp", lane_parity(exp_raw, exp_adtype), j_adp);
  endtask

  task automatic drive_random();
    int r;
    int v;
    r = $random(seed);
    sct_install_state  <= r[3:0];
    sct_unmapped_error <= r[7:4];
    sct_ue_err         <= r[11:8];
    pio_ue             <= r[12];
    unused_jid         <= r[21:16];
    for (int k = 0; k < `PKT_NUM_SCT; k++) begin
      r = $random(seed);
      sct_jid[k]  <= r[5:0];
      sct_data[k] <= {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    r = $random(seed);
    pio_be <= r[15:0];
    pio_ad <= {$random(seed), $random(seed)};
    // About one cycle in four injects errors.
    v = {$random(seed)} % 4;
    if (v == 0) begin
      v = 1 + ({$random(seed)} % 15);
      inj_err_j_ad <= v[3:0];
    end else begin
      inj_err_j_ad <= '0;
    end
    v = {$random(seed)} % 8;
    if (v == 0) begin
      v = {$random(seed)} % 6;
      sel_queue   <= queue_list[v];
      sel_j_adbus <= SEL_IDLE;
    end else begin
      v = {$random(seed)} % 5;
      sel_queue <= queue_list[v];
      if (v < `PKT_NUM_SCT) begin
        v = {$random(seed)} % 6;
        sel_j_adbus <= sct_sel_list[v];
      end else begin
        v = {$random(seed)} % 3;
        sel_j_adbus <= pio_sel_list[v];
      end
    end
  endtask

  initial begin
    // RD64_1 on queue 0 with ue set, the delayed bit stays 0 through reset.
    sel_queue          = LRQ_SCT0RDQ;
    sel_j_adbus        = SEL_RD64_1;
    sct_install_state  = '0;
    sct_unmapped_error = '0;
    sct_ue_err         = '1;
    for (int k = 0; k < `PKT_NUM_SCT; k++) begin
      sct_jid[k]  = '0;
      sct_data[k] = '0;
    end
    pio_ue       = 1'b0;
    pio_be       = '0;
    pio_ad       = '0;
    unused_jid   = '0;
    inj_err_j_ad = '0;

    while (reset !== 1'b0) begin
      @(negedge clk);
      check_outputs();
      @(posedge clk);
    end

    for (int n = 0; n < N_TESTS; n++) begin
      drive_random();
      @(negedge clk);
      check_outputs();
      @(posedge clk);
    end

    $display("Errors: j_adtype %0d, j_ad %0d, j_adp %0d", err_adtype, err_ad, err_adp);
    if (err_adtype + err_ad + err_adp == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 5,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;

  always #(HALF_PERIOD) clk = ~clk;

  // Reset held for a fixed number of rising edges.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== verilog/jbus_cycle_select.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module jbus_cycle_select (
  input  pktout_pkg::lrq_e    sel_queue,
  input  pktout_pkg::jsel_e   sel_j_adbus,
  input  pktout_pkg::adtype_t sct_adtype [`PKT_NUM_SCT],
  input  pktout_pkg::ad_t     sct_ad [`PKT_NUM_SCT],
  input  pktout_pkg::adtype_t pio_adtype,
  input  pktout_pkg::ad_t     pio_ad,
  output pktout_pkg::adtype_t raw_adtype,
  output pktout_pkg::ad_t     raw_ad
);
  import pktout_pkg::*;

  logic       is_sct_queue;
  logic       is_sct_sel;
  logic       is_pio_sel;
  logic [1:0] sct_idx;

  assign is_sct_queue = (sel_queue == LRQ_SCT0RDQ) || (sel_queue == LRQ_SCT1RDQ) ||
                        (sel_queue == LRQ_SCT2RDQ) || (sel_queue == LRQ_SCT3RDQ);

  assign is_sct_sel = (sel_j_adbus == SEL_RD16)   || (sel_j_adbus == SEL_RD64_0) ||
                      (sel_j_adbus == SEL_RD64_1) || (sel_j_adbus == SEL_RD64_2) ||
                      (sel_j_adbus == SEL_RD64_3) || (sel_j_adbus == SEL_RDER);

  assign is_pio_sel = (sel_j_adbus == SEL_NCRD) || (sel_j_adbus == SEL_NCWR_0) ||
                      (sel_j_adbus == SEL_NCWR_1);

  // SCT queue codes are the array index.
  assign sct_idx = sel_queue[1:0];

  always_comb begin
    raw_adtype = '0;
    raw_ad     = '0;
    if (sel_j_adbus == SEL_IDLE) begin
      // Idle cycle is an undriven bus, all ones.
      raw_adtype = '1;
      raw_ad     = '1;
    end else if (is_sct_queue && is_sct_sel) begin
      raw_adtype = sct_adtype[sct_idx];
      raw_ad     = sct_ad[sct_idx];
    end else if ((sel_queue == LRQ_PIORQQ) && is_pio_sel) begin
      raw_adtype = pio_adtype;
      raw_ad     = pio_ad;
    end
  end

endmodule

// ==== verilog/jbus_parity_inject.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module jbus_parity_inject (
  input  pktout_pkg::adtype_t    raw_adtype,
  input  pktout_pkg::ad_t        raw_ad,
  input  logic [`PKT_ADP_W-1:0]  inj_err_j_ad,
  output pktout_pkg::adtype_t    j_adtype,
  output pktout_pkg::ad_t        j_ad,
  output pktout_pkg::adp_t       j_adp
);
  import pktout_pkg::*;

  ad_t inj_mask;

  // Odd parity per lane over clean data, type folded into the top lane.
  always_comb begin
    inj_mask = '0;
    for (int i = 0; i < `PKT_ADP_W; i++) begin
      j_adp[i] = ~(^raw_ad[i*`PKT_LANE_W +: `PKT_LANE_W]);
      inj_mask[i*`PKT_LANE_W] = inj_err_j_ad[i];
    end
    j_adp[`PKT_ADP_W-1] = j_adp[`PKT_ADP_W-1] ^ (^raw_adtype);
  end

  assign j_adtype = raw_adtype;
  assign j_ad     = raw_ad ^ inj_mask;

endmodule

// ==== verilog/pio_formatter.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module pio_formatter (
  input  pktout_pkg::jsel_e         sel_j_adbus,
  input  logic                      pio_ue,
  input  logic [`PKT_BE_W-1:0]       pio_be,
  input  logic [`PKT_PIO_DATA_W-1:0] pio_ad,
  input  pktout_pkg::jid_t          unused_jid,
  output pktout_pkg::adtype_t       adtype,
  output pktout_pkg::ad_t           ad
);
  import pktout_pkg::*;

  logic [`PKT_PIO_DATA_W-1:0] ncrd_half;
  logic [`PKT_PIO_DATA_W-1:0] ncwr_half;

  // Address cycle half: byte enables, transaction code, address.
  assign ncrd_half = {pio_be, TRANS_NCRD, pio_ad[`PKT_PIO_ADDR_W-1:0]};
  assign ncwr_half = {pio_be, TRANS_NCWR, pio_ad[`PKT_PIO_ADDR_W-1:0]};

  always_comb begin
    adtype = '0;
    ad     = '0;
    case (sel_j_adbus)
      SEL_NCRD: begin
        adtype = {2'h3, unused_jid};
        ad     = {ncrd_half, ncrd_half};
      end
      SEL_NCWR_0: begin
        adtype = {2'h3, 6'h00};
        ad     = {ncwr_half, ncwr_half};
      end
      SEL_NCWR_1: begin
        // Data beat, only the UE flag in the type.
        adtype = {3'h0, pio_ue, 4'h0};
        ad     = {pio_ad, pio_ad};
      end
      default: begin
        adtype = '0;
        ad     = '0;
      end
    endcase
  end

endmodule

// ==== verilog/pktout_macros.svh ====
`ifndef PKTOUT_MACROS_SVH
`define PKTOUT_MACROS_SVH

// JBus AD bus.
`define PKT_AD_W 128
`define PKT_ADTYPE_W 8

// Odd parity, one bit per 32-bit lane.
`define PKT_ADP_W 4
`define PKT_LANE_W 32

// Transaction id, split into target aid and trans id.
`define PKT_JID_W 6

// Read-return queues from the L2 tags.
`define PKT_NUM_SCT 4

// PIO request fields.
`define PKT_PIO_ADDR_W 43
`define PKT_PIO_DATA_W 64
`define PKT_BE_W 16

`endif

// ==== verilog/pktout_mux.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module pktout_mux (
  input  logic                      clk,
  input  logic                      reset,
  input  pktout_pkg::lrq_e          sel_queue,
  input  pktout_pkg::jsel_e         sel_j_adbus,
  input  logic                      sct0_install_state,
  input  logic                      sct0_unmapped_error,
  input  pktout_pkg::jid_t          sct0_jid,
  input  pktout_pkg::ad_t           sct0_data,
  input  logic                      sct0_ue_err,
  input  logic                      sct1_install_state,
  input  logic                      sct1_unmapped_error,
  input  pktout_pkg::jid_t          sct1_jid,
  input  pktout_pkg::ad_t           sct1_data,
  input  logic                      sct1_ue_err,
  input  logic                      sct2_install_state,
  input  logic                      sct2_unmapped_error,
  input  pktout_pkg::jid_t          sct2_jid,
  input  pktout_pkg::ad_t           sct2_data,
  input  logic                      sct2_ue_err,
  input  logic                      sct3_install_state,
  input  logic                      sct3_unmapped_error,
  input  pktout_pkg::jid_t          sct3_jid,
  input  pktout_pkg::ad_t           sct3_data,
  input  logic                      sct3_ue_err,
  input  logic                      pio_ue,
  input  logic [`PKT_BE_W-1:0]       pio_be,
  input  logic [`PKT_PIO_DATA_W-1:0] pio_ad,
  input  pktout_pkg::jid_t          unused_jid,
  input  logic [`PKT_ADP_W-1:0]      inj_err_j_ad,
  output pktout_pkg::adtype_t       j_adtype,
  output pktout_pkg::ad_t           j_ad,
  output pktout_pkg::adp_t          j_adp
);
  import pktout_pkg::*;

  logic [`PKT_NUM_SCT-1:0] q_install_state;
  logic [`PKT_NUM_SCT-1:0] q_unmapped_error;
  logic [`PKT_NUM_SCT-1:0] q_ue_err;
  jid_t                    q_jid [`PKT_NUM_SCT];
  ad_t                     q_data [`PKT_NUM_SCT];
  adtype_t                 sct_adtype [`PKT_NUM_SCT];
  ad_t                     sct_ad [`PKT_NUM_SCT];
  adtype_t                 pio_fmt_adtype;
  ad_t                     pio_fmt_ad;
  adtype_t                 raw_adtype;
  ad_t                     raw_ad;

  // Gather per-queue inputs, index is the queue number.
  assign q_install_state  = {sct3_install_state, sct2_install_state,
                             sct1_install_state, sct0_install_state};
  assign q_unmapped_error = {sct3_unmapped_error, sct2_unmapped_error,
                             sct1_unmapped_error, sct0_unmapped_error};
  assign q_ue_err         = {sct3_ue_err, sct2_ue_err, sct1_ue_err, sct0_ue_err};
  assign q_jid            = '{sct0_jid, sct1_jid, sct2_jid, sct3_jid};
  assign q_data           = '{sct0_data, sct1_data, sct2_data, sct3_data};

  for (genvar k = 0; k < `PKT_NUM_SCT; k++) begin : g_sct
    rdq_formatter u_rdq_formatter (
      .clk            (clk),
      .reset          (reset),
      .sel_j_adbus    (sel_j_adbus),
      .install_state  (q_install_state[k]),
      .unmapped_error (q_unmapped_error[k]),
      .ue_err         (q_ue_err[k]),
      .jid            (q_jid[k]),
      .data           (q_data[k]),
      .adtype         (sct_adtype[k]),
      .ad             (sct_ad[k])
    );
  end

  pio_formatter u_pio_formatter (
    .sel_j_adbus (sel_j_adbus),
    .pio_ue      (pio_ue),
    .pio_be      (pio_be),
    .pio_ad      (pio_ad),
    .unused_jid  (unused_jid),
    .adtype      (pio_fmt_adtype),
    .ad          (pio_fmt_ad)
  );

  jbus_cycle_select u_jbus_cycle_select (
    .sel_queue   (sel_queue),
    .sel_j_adbus (sel_j_adbus),
    .sct_adtype  (sct_adtype),
    .sct_ad      (sct_ad),
    .pio_adtype  (pio_fmt_adtype),
    .pio_ad      (pio_fmt_ad),
    .raw_adtype  (raw_adtype),
    .raw_ad      (raw_ad)
  );

  jbus_parity_inject u_jbus_parity_inject (
    .raw_adtype   (raw_adtype),
    .raw_ad       (raw_ad),
    .inj_err_j_ad (inj_err_j_ad),
    .j_adtype     (j_adtype),
    .j_ad         (j_ad),
    .j_adp        (j_adp)
  );

endmodule

// ==== verilog/pktout_pkg.sv ====
`include "pktout_macros.svh"

package pktout_pkg;

  // Queue select from the scheduler.
  typedef enum logic [2:0] {
    LRQ_SCT0RDQ = 3'd0,
    LRQ_SCT1RDQ = 3'd1,
    LRQ_SCT2RDQ = 3'd2,
    LRQ_SCT3RDQ = 3'd3,
    LRQ_PIORQQ  = 3'd4,
    LRQ_IDLE    = 3'd5
  } lrq_e;

  // Bus-cycle select.
  typedef enum logic [3:0] {
    SEL_IDLE   = 4'd0,
    SEL_RD16   = 4'd1,
    SEL_RD64_0 = 4'd2,
    SEL_RD64_1 = 4'd3,
    SEL_RD64_2 = 4'd4,
    SEL_RD64_3 = 4'd5,
    SEL_RDER   = 4'd6,
    SEL_NCRD   = 4'd7,
    SEL_NCWR_0 = 4'd8,
    SEL_NCWR_1 = 4'd9
  } jsel_e;

  typedef enum logic [4:0] {
    TRANS_NCRD = 5'b10010,
    TRANS_NCWR = 5'b10110
  } trans_e;

  typedef enum logic [2:0] {
    INSTALL_SHARED  = 3'b011,
    INSTALL_INVALID = 3'b000
  } install_e;

  typedef enum logic [2:0] {
    RDER_BUS_ERROR = 3'b001,
    RDER_UNMAPPED  = 3'b010
  } rder_e;

  typedef logic [`PKT_ADTYPE_W-1:0] adtype_t;
  typedef logic [`PKT_AD_W-1:0]     ad_t;
  typedef logic [`PKT_ADP_W-1:0]    adp_t;
  typedef logic [`PKT_JID_W-1:0]    jid_t;

endpackage

// ==== verilog/rdq_formatter.sv ====
`timescale 1ns/1ps

`include "pktout_macros.svh"

module rdq_formatter (
  input  logic                clk,
  input  logic                reset,
  input  pktout_pkg::jsel_e   sel_j_adbus,
  input  logic                install_state,
  input  logic                unmapped_error,
  input  logic                ue_err,
  input  pktout_pkg::jid_t    jid,
  input  pktout_pkg::ad_t     data,
  output pktout_pkg::adtype_t adtype,
  output pktout_pkg::ad_t     ad
);
  import pktout_pkg::*;

  logic       ue_err_p1;
  logic [3:0] target_aid;
  logic [1:0] trans_id;
  logic [1:0] uece;
  logic [1:0] uece_p1;
  install_e   state;
  rder_e      rder_code;

  // UE flag of the previous beat, shown on RD64_1.
  always_ff @(posedge clk) begin
    if (reset) begin
      ue_err_p1 <= 1'b0;
    end else begin
      ue_err_p1 <= ue_err;
    end
  end

  assign target_aid = jid[`PKT_JID_W-1:2];
  assign trans_id   = jid[1:0];
  assign uece       = {ue_err, 1'b0};
  assign uece_p1    = {ue_err_p1, 1'b0};
  assign state      = install_state ? INSTALL_INVALID : INSTALL_SHARED;
  assign rder_code  = unmapped_error ? RDER_UNMAPPED : RDER_BUS_ERROR;

  always_comb begin
    adtype = '0;
    ad     = '0;
    case (sel_j_adbus)
      SEL_RD16: begin
        adtype = {2'h2, target_aid, trans_id};
        ad     = data;
      end
      SEL_RD64_0: begin
        adtype = {2'h1, target_aid, trans_id};
        ad     = data;
      end
      SEL_RD64_1: begin
        adtype = {1'b0, uece_p1, uece, state};
        ad     = data;
      end
      SEL_RD64_2, SEL_RD64_3: begin
        adtype = {3'h0, uece, 3'h0};
        ad     = data;
      end
      SEL_RDER: begin
        adtype = {2'h0, target_aid, trans_id};
        // Error code replaces the low data bits.
        ad     = {data[`PKT_AD_W-1:3], rder_code};
      end
      default: begin
        adtype = '0;
        ad     = '0;
      end
    endcase
  end

endmodule
